// File: rtl/qkv_pkg.sv
/*
 * Widths and word types shared by the projection engine and its testbench.
 * Import with qkv_pkg::* in the module header.
 */
package qkv_pkg;

	//----------------------------------------------------------------------
	// SRAM geometry
	//----------------------------------------------------------------------
	localparam int addr_w = 16;
	localparam int data_w = 32;

	typedef logic [addr_w-1:0]   addr_t;
	typedef logic [data_w-1:0]   data_t;
	typedef logic [data_w/2-1:0] dim_t;   // one matrix dimension

	//----------------------------------------------------------------------
	// one SRAM word, either a header or a matrix element
	//----------------------------------------------------------------------
	typedef union packed {
		struct packed {
			dim_t rows;   // upper half word
			dim_t cols;   // lower half word
		} hdr;
		data_t elem;      // plain integer element
	} sram_word_u;

endpackage

// File: rtl/mat_ctrl_if.sv
/*
 * Control and status strobes between the job FSM and the datapath blocks.
 * One modport per block; all signals are single-bit and cycle aligned.
 */
`timescale 1ns/1ps

interface mat_ctrl_if;

	// driven by the FSM
	logic load_dims;   // header words on the read data buses
	logic issue;       // operand address pair on the read ports
	logic acc_en;      // operand data valid this cycle
	logic write_last;  // accumulate total is final this cycle

	// driven by the operand fetch
	logic k_last;      // pair being issued closes its element
	logic all_last;    // pair being issued closes the job

	modport ctrl (
		output load_dims,
		output issue,
		output acc_en,
		output write_last,
		input  k_last,
		input  all_last
	);

	modport fetch (
		input  load_dims,
		input  issue,
		output k_last,
		output all_last
	);

	modport mac (
		input acc_en,
		input write_last
	);

	modport writer (
		input load_dims,
		input acc_en,
		input write_last
	);

endinterface

// File: rtl/qkv_ctrl.sv
/*
 * Job FSM of the projection engine. Sequences header read, dimension load,
 * operand issue and pipeline drain, and owns dut_ready.
 */
`timescale 1ns/1ps

module qkv_ctrl (
	input  logic clk,
	input  logic reset_n,
	input  logic dut_valid,
	output logic dut_ready,
	mat_ctrl_if.ctrl ctl
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_HEADER,   // header address on the read ports
		ST_LOAD,     // header data on the read buses
		ST_RUN,      // one operand pair per cycle
		ST_DRAIN     // mac and write stages empty out
	} state_t;

	state_t state;
	state_t state_next;
	logic   drain_cnt;

	//----------------------------------------------------------------------
	// next state
	//----------------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (dut_valid && dut_ready)
					state_next = ST_HEADER;
			end
			ST_HEADER: begin
				state_next = ST_LOAD;
			end
			ST_LOAD: begin
				state_next = ST_RUN;
			end
			ST_RUN: begin
				// last pair of the job goes out this cycle
				if (ctl.all_last)
					state_next = ST_DRAIN;
			end
			ST_DRAIN: begin
				if (drain_cnt)
					state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	//----------------------------------------------------------------------
	// state, drain count and ready
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= ST_IDLE;
			drain_cnt <= 1'b0;
			dut_ready <= 1'b0;
		end else begin
			state     <= state_next;
			dut_ready <= (state_next == ST_IDLE);   // high only while idle

			if (state == ST_DRAIN)
				drain_cnt <= ~drain_cnt;
			else
				drain_cnt <= 1'b0;
		end
	end

	// strobes decoded straight from the state
	assign ctl.load_dims = (state == ST_LOAD);
	assign ctl.issue     = (state == ST_RUN);

	//----------------------------------------------------------------------
	// delayed strobes, aligned with the read data
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ctl.acc_en     <= 1'b0;
			ctl.write_last <= 1'b0;
		end else begin
			ctl.acc_en     <= ctl.issue;
			ctl.write_last <= ctl.issue & ctl.k_last;   // closes an element next cycle
		end
	end

endmodule

// File: rtl/operand_fetch.sv
/*
 * Dimension registers, p/i/j/k loop counters and the input and weight
 * read addresses. One address pair goes out per issue cycle.
 */
`timescale 1ns/1ps

module operand_fetch import qkv_pkg::*; #(
	parameter int num_proj = 3
) (
	input  logic  clk,
	input  logic  reset_n,
	input  data_t input_read_data,
	input  data_t weight_read_data,
	output addr_t input_read_address,
	output addr_t weight_read_address,
	mat_ctrl_if.fetch ctl
);

	sram_word_u in_hdr;
	sram_word_u w_hdr;
	dim_t       rows_i, cols_i, cols_w;
	dim_t       p, i, j, k;
	addr_t      row_base;   // input row start
	addr_t      col_base;   // weight column start
	addr_t      mat_base;   // weight matrix start
	logic       k_end, j_end, i_end, p_end;

	assign in_hdr = input_read_data;
	assign w_hdr  = weight_read_data;

	// rows_w equals cols_i, so only three dimensions are kept
	always_ff @(posedge clk) begin
		if (ctl.load_dims) begin
			rows_i <= in_hdr.hdr.rows;
			cols_i <= in_hdr.hdr.cols;
			cols_w <= w_hdr.hdr.cols;
		end
	end

	assign k_end = (k == cols_i - dim_t'(1));
	assign j_end = (j == cols_w - dim_t'(1));
	assign i_end = (i == rows_i - dim_t'(1));
	assign p_end = (p == dim_t'(num_proj - 1));

	assign ctl.k_last   = k_end;
	assign ctl.all_last = k_end & j_end & i_end & p_end;

	//----------------------------------------------------------------------
	// nested counters and running addresses
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			{p, i, j, k} <= '0;
			input_read_address  <= '0;
			weight_read_address <= '0;
			row_base <= '0;
			col_base <= '0;
			mat_base <= '0;
		end else if (ctl.load_dims) begin
			{p, i, j, k} <= '0;
			input_read_address  <= addr_t'(1);   // first element after header
			weight_read_address <= addr_t'(1);
			row_base <= addr_t'(1);
			col_base <= addr_t'(1);
			mat_base <= addr_t'(1);
		end else if (ctl.issue) begin
			if (!k_end) begin
				k <= k + dim_t'(1);
				input_read_address  <= input_read_address + addr_t'(1);
				weight_read_address <= weight_read_address + cols_w;   // down the column
			end else begin
				k <= '0;
				if (!j_end) begin
					// same input row, next weight column
					j <= j + dim_t'(1);
					input_read_address  <= row_base;
					weight_read_address <= col_base + addr_t'(1);
					col_base <= col_base + addr_t'(1);
				end else begin
					j <= '0;
					if (!i_end) begin
						i <= i + dim_t'(1);
						input_read_address  <= row_base + cols_i;
						row_base            <= row_base + cols_i;
						weight_read_address <= mat_base;
						col_base            <= mat_base;
					end else begin
						i <= '0;
						if (!p_end) begin
							// next matrix starts right after the last weight
							p <= p + dim_t'(1);
							input_read_address  <= addr_t'(1);
							row_base            <= addr_t'(1);
							weight_read_address <= weight_read_address + addr_t'(1);
							col_base            <= weight_read_address + addr_t'(1);
							mat_base            <= weight_read_address + addr_t'(1);
						end else begin
							p <= '0;
							input_read_address  <= '0;   // back to header
							weight_read_address <= '0;
						end
					end
				end
			end
		end
	end

endmodule

// File: rtl/mac_unit.sv
/*
 * 32-bit integer multiply-accumulate with wrap-around.
 * Sum is combinational, the accumulator updates on acc_en.
 */
`timescale 1ns/1ps

module mac_unit import qkv_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  data_t input_read_data,
	input  data_t weight_read_data,
	output data_t mac_sum,
	mat_ctrl_if.mac ctl
);

	sram_word_u in_op;
	sram_word_u w_op;
	data_t      acc;

	assign in_op = input_read_data;
	assign w_op  = weight_read_data;

	// product and sum both truncated to 32 bits
	assign mac_sum = in_op.elem * w_op.elem + acc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			acc <= '0;
		end else if (ctl.acc_en) begin
			if (ctl.write_last)
				acc <= '0;   // element done, start the next from zero
			else
				acc <= mac_sum;
		end
	end

endmodule

// File: rtl/result_writer.sv
/*
 * Result SRAM write port. Captures each finished element and writes it
 * to the next address in order, one pulse per element.
 */
`timescale 1ns/1ps

module result_writer import qkv_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  data_t mac_sum,
	output logic  result_write_enable,
	output addr_t result_write_address,
	output data_t result_write_data,
	mat_ctrl_if.writer ctl
);

	addr_t wr_ptr;    // next result address
	logic  wr_fire;

	assign wr_fire = ctl.acc_en & ctl.write_last;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr               <= '0;
			result_write_enable  <= 1'b0;
			result_write_address <= '0;
			result_write_data    <= '0;
		end else begin
			result_write_enable <= wr_fire;

			if (ctl.load_dims)
				wr_ptr <= '0;   // every job writes from address 0
			else if (wr_fire)
				wr_ptr <= wr_ptr + addr_t'(1);

			if (wr_fire) begin
				result_write_address <= wr_ptr;
				result_write_data    <= mac_sum;
			end
		end
	end

endmodule

// File: rtl/qkv_top.sv
/*
 * Top level of the Q/K/V projection engine with plain SRAM ports.
 * Connects the job FSM to operand fetch, MAC and result writer.
 */
`timescale 1ns/1ps

module qkv_top import qkv_pkg::*; #(
	parameter int num_proj = 3
) (
	input  logic  clk,
	input  logic  reset_n,

	// job handshake
	input  logic  dut_valid,
	output logic  dut_ready,

	// input and weight SRAM read ports
	output addr_t input_read_address,
	input  data_t input_read_data,
	output addr_t weight_read_address,
	input  data_t weight_read_data,

	// result SRAM write port
	output logic  result_write_enable,
	output addr_t result_write_address,
	output data_t result_write_data
);

	data_t mac_sum;

	mat_ctrl_if ctl_if ();

	qkv_ctrl u_qkv_ctrl (
		.clk       (clk),
		.reset_n   (reset_n),
		.dut_valid (dut_valid),
		.dut_ready (dut_ready),
		.ctl       (ctl_if.ctrl)
	);

	operand_fetch #(
		.num_proj (num_proj)
	) u_operand_fetch (
		.clk                 (clk),
		.reset_n             (reset_n),
		.input_read_data     (input_read_data),
		.weight_read_data    (weight_read_data),
		.input_read_address  (input_read_address),
		.weight_read_address (weight_read_address),
		.ctl                 (ctl_if.fetch)
	);

	mac_unit u_mac_unit (
		.clk              (clk),
		.reset_n          (reset_n),
		.input_read_data  (input_read_data),
		.weight_read_data (weight_read_data),
		.mac_sum          (mac_sum),
		.ctl              (ctl_if.mac)
	);

	result_writer u_result_writer (
		.clk                  (clk),
		.reset_n              (reset_n),
		.mac_sum              (mac_sum),
		.result_write_enable  (result_write_enable),
		.result_write_address (result_write_address),
		.result_write_data    (result_write_data),
		.ctl                  (ctl_if.writer)
	);

endmodule

// File: bench/qkv_sva.sv
/*
 * Protocol assertions for the projection engine, bound into qkv_top.
 */
`timescale 1ns/1ps

module qkv_sva import qkv_pkg::*; (
	input logic  clk,
	input logic  reset_n,
	input logic  dut_valid,
	input logic  dut_ready,
	input logic  result_write_enable,
	input addr_t result_write_address
);

	addr_t last_addr;    // address of the previous write
	logic  seen_write;   // a write already happened in this job

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			last_addr  <= '0;
			seen_write <= 1'b0;
		end else if (dut_ready) begin
			seen_write <= 1'b0;
		end else if (result_write_enable) begin
			seen_write <= 1'b1;
			last_addr  <= result_write_address;
		end
	end

	a_no_write_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
		!(result_write_enable && dut_ready))
		else $error("result write while dut_ready is high");

	a_start_drops_ready: assert property (@(posedge clk) disable iff (!reset_n)
		dut_valid && dut_ready |=> !dut_ready)
		else $error("dut_ready still high after an accepted start");

	a_write_addr_step: assert property (@(posedge clk) disable iff (!reset_n)
		result_write_enable && seen_write |-> result_write_address == last_addr + addr_t'(1))
		else $error("result write address did not follow the previous one");

endmodule

bind qkv_top qkv_sva u_qkv_sva (
	.clk                  (clk),
	.reset_n              (reset_n),
	.dut_valid            (dut_valid),
	.dut_ready            (dut_ready),
	.result_write_enable  (result_write_enable),
	.result_write_address (result_write_address)
);

// File: bench/tb_qkv.sv
/*
 * Testbench for qkv_top. SRAM models, LFSR stimulus and a reference model
 * of the Q/K/V projections; every result address is compared after each job.
 */
`timescale 1ns/1ps

module tb_qkv import qkv_pkg::*; #(
	parameter int num_proj = 3
);

	localparam int ready_timeout = 2000;   // cycles per job, longest needs about 1.6k

	logic  clk;
	logic  reset_n;
	logic  dut_valid;
	logic  dut_ready;
	addr_t input_read_address;
	data_t input_read_data;
	addr_t weight_read_address;
	data_t weight_read_data;
	logic  result_write_enable;
	addr_t result_write_address;
	data_t result_write_data;

	data_t input_mem    [0:65535];
	data_t weight_mem   [0:65535];
	data_t result_mem   [0:65535];
	data_t expected_mem [0:65535];
	addr_t in_addr_q;
	addr_t w_addr_q;

	logic [15:0] lfsr_state;
	string       cur_test;
	int          write_count;
	int          write_total;
	int          error_count;
	int          tests_run;
	int          tests_failed;
	bit          aborted;

	qkv_top #(
		.num_proj (num_proj)
	) u_qkv_top (
		.clk                  (clk),
		.reset_n              (reset_n),
		.dut_valid            (dut_valid),
		.dut_ready            (dut_ready),
		.input_read_address   (input_read_address),
		.input_read_data      (input_read_data),
		.weight_read_address  (weight_read_address),
		.weight_read_data     (weight_read_data),
		.result_write_enable  (result_write_enable),
		.result_write_address (result_write_address),
		.result_write_data    (result_write_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//----------------------------------------------------------------------
	// SRAM models with the address taken on the clock and data out mid-cycle
	//----------------------------------------------------------------------
	always @(posedge clk) begin
		in_addr_q <= input_read_address;
		w_addr_q  <= weight_read_address;
	end

	always @(negedge clk) begin
		input_read_data  <= input_mem[in_addr_q];
		weight_read_data <= weight_mem[w_addr_q];
	end

	// result port monitor and write order check
	always @(negedge clk) begin
		if (reset_n && result_write_enable) begin
			if (write_count >= write_total) begin
				$display("%s: write to address %0d lies beyond the last result address",
					cur_test, result_write_address);
				error_count++;
			end else begin
				check_addr({cur_test, " write order"}, addr_t'(write_count),
					result_write_address);
			end
			result_mem[result_write_address] = result_write_data;
			write_count++;
		end
	end

	//----------------------------------------------------------------------
	// compare tasks
	//----------------------------------------------------------------------
	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
			error_count++;
		end
	endtask

	//----------------------------------------------------------------------
	// stimulus
	//----------------------------------------------------------------------
	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output data_t value);
		value = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic fill_pattern();
		for (int a = 0; a < 65536; a++) begin
			input_mem[addr_t'(a)]  = {~addr_t'(a), addr_t'(a)};
			weight_mem[addr_t'(a)] = {addr_t'(a), ~addr_t'(a)};
			result_mem[addr_t'(a)] = {~addr_t'(a), ~addr_t'(a)};
		end
	endtask

	task automatic fill_fixed();
		for (int i = 0; i < 2; i++)
			for (int k = 0; k < 3; k++)
				input_mem[addr_t'(1 + i*3 + k)] = data_t'(i*3 + k + 1);
		for (int p = 0; p < num_proj; p++)
			for (int k = 0; k < 3; k++)
				for (int j = 0; j < 2; j++)
					weight_mem[addr_t'(1 + p*6 + k*2 + j)] = data_t'((p+1)*10 + k*2 + j);
	endtask

	task automatic fill_random(input int ri, input int ci, input int cw);
		data_t v;
		for (int i = 0; i < ri; i++)
			for (int k = 0; k < ci; k++) begin
				take_bits(32, v);
				input_mem[addr_t'(1 + i*ci + k)] = v;
			end
		for (int p = 0; p < num_proj; p++)
			for (int k = 0; k < ci; k++)
				for (int j = 0; j < cw; j++) begin
					take_bits(32, v);
					weight_mem[addr_t'(1 + p*ci*cw + k*cw + j)] = v;
				end
	endtask

	// operands just around 2^31 so products and sums wrap
	task automatic fill_near_limit(input int ri, input int ci, input int cw);
		data_t v;
		for (int i = 0; i < ri; i++)
			for (int k = 0; k < ci; k++) begin
				take_bits(4, v);
				input_mem[addr_t'(1 + i*ci + k)] = 32'h7fff_fff0 + v;
			end
		for (int p = 0; p < num_proj; p++)
			for (int k = 0; k < ci; k++)
				for (int j = 0; j < cw; j++) begin
					take_bits(4, v);
					weight_mem[addr_t'(1 + p*ci*cw + k*cw + j)] = 32'h8000_0000 + v;
				end
	endtask

	// reference model with rows_w taken equal to cols_i
	task automatic compute_expected(input int ri, input int ci, input int cw);
		data_t acc;
		for (int p = 0; p < num_proj; p++)
			for (int i = 0; i < ri; i++)
				for (int j = 0; j < cw; j++) begin
					acc = '0;
					for (int k = 0; k < ci; k++)
						acc = acc + input_mem[addr_t'(1 + i*ci + k)]
							* weight_mem[addr_t'(1 + p*ci*cw + k*cw + j)];
					expected_mem[addr_t'(p*ri*cw + i*cw + j)] = acc;
				end
	endtask

	//----------------------------------------------------------------------
	// job sequencing
	//----------------------------------------------------------------------
	task automatic wait_ready(input int glitch_at, output bit ok);
		int cycles;
		cycles = 0;
		@(negedge clk);
		dut_valid = 1'b0;
		check_bit({cur_test, " start"}, 1'b0, dut_ready);
		while (!dut_ready && cycles < ready_timeout) begin
			dut_valid = (cycles == glitch_at);   // stray start mid job
			@(negedge clk);
			cycles++;
		end
		dut_valid = 1'b0;
		ok = dut_ready;
		if (!ok)
			$display("%s: dut_ready did not return within %0d cycles", cur_test, ready_timeout);
	endtask

	task automatic report_test(input string name, input int errors_before, input bit ok);
		tests_run++;
		if (ok && error_count == errors_before) begin
			$display("test %-16s ok", name);
		end else begin
			tests_failed++;
			$display("test %-16s failed", name);
		end
	endtask

	task automatic run_job(input string name, input int ri, input int ci, input int cw,
		input int glitch_at);
		sram_word_u hdr;
		int         errors_before;
		int         total;
		bit         ok;
		if (aborted)
			return;
		errors_before = error_count;
		total = num_proj * ri * cw;
		hdr.hdr.rows = dim_t'(ri);
		hdr.hdr.cols = dim_t'(ci);
		input_mem[0] = hdr.elem;
		hdr.hdr.rows = dim_t'(ci);
		hdr.hdr.cols = dim_t'(cw);
		weight_mem[0] = hdr.elem;
		compute_expected(ri, ci, cw);
		for (int a = 0; a < total; a++)
			result_mem[addr_t'(a)] = {~addr_t'(a), ~addr_t'(a)};
		cur_test    = name;
		write_count = 0;
		write_total = total;
		dut_valid   = 1'b1;
		wait_ready(glitch_at, ok);
		if (!ok) begin
			aborted = 1'b1;
		end else begin
			check_addr({name, " write count"}, addr_t'(total), addr_t'(write_count));
			for (int a = 0; a < total; a++)
				check_data($sformatf("%s result[%0d]", name, a),
					expected_mem[addr_t'(a)], result_mem[addr_t'(a)]);
			if (glitch_at >= 0) begin
				@(negedge clk);
				check_bit({name, " idle after job"}, 1'b1, dut_ready);
			end
		end
		report_test(name, errors_before, ok);
	endtask

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial begin
		int ri;
		int ci;
		int cw;
		int errors_before;
		data_t v;
		lfsr_state       = 16'd10105;
		reset_n          = 1'b0;
		dut_valid        = 1'b0;
		input_read_data  <= '0;
		weight_read_data <= '0;
		in_addr_q        <= '0;
		w_addr_q         <= '0;
		cur_test         = "reset";
		write_count      = 0;
		write_total      = 0;
		error_count      = 0;
		tests_run        = 0;
		tests_failed     = 0;
		aborted          = 1'b0;
		fill_pattern();

		// two rising edges with reset low
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		errors_before = error_count;
		check_bit("reset ready", 1'b1, dut_ready);
		check_bit("reset write enable", 1'b0, result_write_enable);
		report_test("reset", errors_before, 1'b1);

		fill_fixed();
		run_job("fixed_2x3x2", 2, 3, 2, -1);

		for (int n = 0; n < 10; n++) begin
			take_bits(3, v);
			ri = int'(v[2:0]) + 1;
			take_bits(3, v);
			ci = int'(v[2:0]) + 1;
			take_bits(3, v);
			cw = int'(v[2:0]) + 1;
			fill_random(ri, ci, cw);
			run_job($sformatf("random_%0d", n), ri, ci, cw, -1);
		end

		fill_random(4, 5, 3);
		run_job("valid_mid_job", 4, 5, 3, 6);

		fill_near_limit(2, 2, 3);
		run_job("wrap_2x2x3", 2, 2, 3, -1);
		fill_near_limit(1, 1, 1);
		run_job("wrap_1x1x1", 1, 1, 1, -1);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0 && !aborted)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: sources.f
rtl/qkv_pkg.sv
rtl/mat_ctrl_if.sv
rtl/qkv_ctrl.sv
rtl/operand_fetch.sv
rtl/mac_unit.sv
rtl/result_writer.sv
rtl/qkv_top.sv
bench/qkv_sva.sv
bench/tb_qkv.sv

// File: Makefile
# Verilator build and run for the Q/K/V projection engine

VERILATOR ?= verilator
TOP       ?= tb_qkv
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
